//--- exec_core.f
+incdir+include
rtl/exec_core_pkg.sv
rtl/regfile.sv
rtl/alu.sv
rtl/operand_bypass.sv
rtl/exec_control.sv
rtl/exec_core.sv
verification/exec_core_tb.sv

//--- Makefile
# Verilator build and run of the execute core testbench
TOP := exec_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f exec_core.f -Mdir obj_dir

# the run passes only when the testbench prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- verification/exec_core_tb.sv
// testbench for the execute core: clock, reset, lcg stimulus, reference model, compare tasks, watchdog
`timescale 1ns/100ps
`include "exec_core_cfg.svh"

module exec_core_tb;

    import exec_core_pkg::*;

    localparam int NUM_RANDOM   = 2000;
    localparam int NUM_DIRECTED = 64; // reset sweep, directed words and drain, rounded up

    logic                   clock;
    logic                   rst;
    logic                   insn_valid;
    insn_u                  insn;
    wb_t                    wb;
    logic                   ovf;

    logic [`DATA_WIDTH-1:0] mregs [`REG_COUNT]; // architectural state as the model sees it
    wb_t                    exp_wb;
    logic                   exp_ovf;
    logic [31:0]            lcg_state;
    int                     errors;

    exec_core exec_core_i (
        .clock      (clock),
        .rst        (rst),
        .insn_valid (insn_valid),
        .insn       (insn),
        .wb         (wb),
        .ovf        (ovf)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ############################################################
    // stimulus helpers
    // ############################################################

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // low registers most of the time so that results get reused
    function automatic logic [4:0] pick_reg(input logic [31:0] r);
        if (r[3:0] < 4'd10) begin
            return {2'b00, r[6:4]};
        end else if (r[3:0] < 4'd12) begin
            return 5'd30; // the status register is read back now and then
        end
        return r[8:4];
    endfunction

    function automatic insn_u r_word(input alu_op_e op, input logic [4:0] rd,
                                     input logic [4:0] rs, input logic [4:0] rt,
                                     input logic [4:0] sh);
        insn_u w;
        w.r = '{OP_ALU, rd, rs, rt, sh, op, 2'b00};
        return w;
    endfunction

    function automatic insn_u i_word(input logic [4:0] rd, input logic [4:0] rs,
                                     input logic [16:0] imm);
        insn_u w;
        w.i = '{OP_ADDI, rd, rs, imm};
        return w;
    endfunction

    task automatic random_insn(output logic v, output insn_u w);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        alu_op_e     op;
        r1 = lcg_next();
        r2 = lcg_next();
        r3 = lcg_next();
        v  = (r1[3:0] > 4'd1); // roughly one idle cycle in eight
        if (r1[7:4] == 4'd0) begin
            w = {r2[4:0], r3[26:0]}; // stray opcode, mostly not decodable
        end else if (r1[7:4] < 4'd6) begin
            w = i_word(pick_reg(r2), pick_reg(r2 >> 10), r3[16:0]);
        end else begin
            op = (r1[11:8] == 4'd0) ? alu_op_e'(r3[9:5]) : alu_op_e'(r3[9:5] % 5'd6);
            w  = r_word(op, pick_reg(r2), pick_reg(r2 >> 10), pick_reg(r2 >> 20), r3[4:0]);
        end
    endtask

    // ############################################################
    // reference model
    // ############################################################

    // the model updates its registers at issue, which is what the bypass makes visible
    task automatic model_issue(input logic v, input insn_u w,
                               output wb_t e_wb, output logic e_ovf);
        logic                   is_i;
        logic                   legal;
        logic                   ov;
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] res;
        logic [`DATA_WIDTH-1:0] code;
        logic [`DATA_WIDTH:0]   wide;
        is_i  = (w.i.opcode == OP_ADDI);
        legal = is_i || ((w.r.opcode == OP_ALU) &&
                         (w.r.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRA}));
        a     = mregs[w.r.rs];
        b     = is_i ? {{15{w.i.imm[16]}}, w.i.imm} : mregs[w.r.rt]; // 17-bit imm widened
        ov    = 1'b0;
        res   = '0;
        code  = 32'd1;
        wide  = '0;
        if (is_i) begin
            wide = {a[31], a} + {b[31], b};
            code = 32'd2;
        end else if (w.r.alu_op == ALU_SUB) begin
            wide = {a[31], a} - {b[31], b};
            code = 32'd3;
        end else begin
            wide = {a[31], a} + {b[31], b};
        end
        if (is_i) begin
            res = wide[31:0];
            ov  = (wide[32] != wide[31]); // the extra sign bit disagrees on overflow
        end else begin
            case (w.r.alu_op)
                ALU_ADD, ALU_SUB: begin
                    res = wide[31:0];
                    ov  = (wide[32] != wide[31]);
                end
                ALU_AND: res = a & b;
                ALU_OR:  res = a | b;
                ALU_SLL: res = a << w.r.shamt;
                ALU_SRA: res = $signed(a) >>> w.r.shamt;
                default: res = '0;
            endcase
        end
        e_wb  = '0;
        e_ovf = 1'b0;
        if (v && legal) begin
            e_wb.valid = 1'b1;
            e_ovf      = ov;
            e_wb.rd    = ov ? `REG_IDX_W'(`RSTATUS_REG) : w.r.rd;
            e_wb.data  = ov ? code : res;
            if (e_wb.rd != '0) begin
                mregs[e_wb.rd] = e_wb.data;
            end
        end
    endtask

    // ############################################################
    // checks
    // ############################################################

    // target and data carry no meaning while valid is low
    task automatic compare_wb(input wb_t expected, input wb_t actual);
        if (!expected.valid && (actual.valid !== 1'b0)) begin
            errors++;
            $display("mismatch at %0t: wb.valid expected 0 actual %b", $time, actual.valid);
        end else if (expected.valid && (actual !== expected)) begin
            errors++;
            $display("mismatch at %0t: wb expected v=%b rd=%0d d=%h actual v=%b rd=%0d d=%h",
                     $time, expected.valid, expected.rd, expected.data,
                     actual.valid, actual.rd, actual.data);
        end
    endtask

    task automatic compare_ovf(input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: ovf expected %b actual %b", $time, expected, actual);
        end
    endtask

    // drive on the rising edge, check the previous word at the falling edge
    task automatic issue(input logic v, input insn_u w);
        wb_t  nxt_wb;
        logic nxt_ovf;
        @(posedge clock);
        insn_valid <= v;
        insn       <= w;
        model_issue(v, w, nxt_wb, nxt_ovf);
        @(negedge clock);
        compare_wb(exp_wb, wb);
        compare_ovf(exp_ovf, ovf);
        exp_wb  = nxt_wb;
        exp_ovf = nxt_ovf;
    endtask

    // ############################################################
    // test sequence
    // ############################################################

    initial begin
        logic  v;
        insn_u w;
        lcg_state  = 32'd54259;
        rst        = 1'b1;
        insn_valid = 1'b0;
        insn       = '0;
        exp_wb     = '0;
        exp_ovf    = 1'b0;
        errors     = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            mregs[i] = '0;
        end
        repeat (4) @(posedge clock);
        rst <= 1'b0;

        // every register reads zero after reset, results land in r0 and vanish
        for (int i = 0; i < `REG_COUNT; i++) begin
            issue(1'b1, r_word(ALU_OR, 5'd0, 5'(i), 5'(i), 5'd0));
        end

        // dependent chain that builds large values and hits each overflow code
        issue(1'b1, i_word(5'd1, 5'd0, 17'd1));
        issue(1'b1, r_word(ALU_SLL, 5'd2, 5'd1, 5'd0, 5'd30));
        issue(1'b1, r_word(ALU_ADD, 5'd3, 5'd2, 5'd2, 5'd0));   // code 1
        issue(1'b1, r_word(ALU_SLL, 5'd5, 5'd1, 5'd0, 5'd31));
        issue(1'b1, r_word(ALU_SUB, 5'd6, 5'd2, 5'd5, 5'd0));   // code 3
        issue(1'b1, i_word(5'd8, 5'd2, 17'h1ffff));
        issue(1'b1, r_word(ALU_ADD, 5'd9, 5'd2, 5'd8, 5'd0));
        issue(1'b1, i_word(5'd10, 5'd9, 17'd1));                 // code 2
        issue(1'b1, i_word(5'd11, 5'd0, 17'h1fffb));             // negative immediate
        issue(1'b1, r_word(ALU_SRA, 5'd12, 5'd11, 5'd0, 5'd1));
        issue(1'b1, r_word(ALU_AND, 5'd13, 5'd9, 5'd11, 5'd0));
        issue(1'b1, i_word(5'd0, 5'd0, 17'd123));
        issue(1'b1, r_word(ALU_OR, 5'd14, 5'd0, 5'd0, 5'd0));
        issue(1'b0, r_word(ALU_ADD, 5'd15, 5'd1, 5'd1, 5'd0));
        issue(1'b1, {5'd7, 27'h12345});                          // unknown opcode

        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_insn(v, w);
            issue(v, w);
        end
        issue(1'b0, '0);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #((NUM_RANDOM + NUM_DIRECTED + 100) * 10);
        $display("timeout: the test sequence did not reach its end");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- rtl/exec_core.sv
// execute core top: control, register file, operand bypass and alu
`timescale 1ns/100ps
`include "exec_core_cfg.svh"

module exec_core (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 insn_valid,
    input  exec_core_pkg::insn_u insn,
    output exec_core_pkg::wb_t   wb,
    output logic                 ovf
);

    import exec_core_pkg::*;

    ex_ctrl_t               ex_ctrl;
    logic [`DATA_WIDTH-1:0] rf_a;
    logic [`DATA_WIDTH-1:0] rf_b;
    logic [`DATA_WIDTH-1:0] op_a;
    logic [`DATA_WIDTH-1:0] op_b;
    logic [`DATA_WIDTH-1:0] alu_result;
    logic                   alu_overflow;

    // decode happens in the same cycle the word is presented
    exec_control exec_control_i (
        .clock        (clock),
        .rst          (rst),
        .insn_valid   (insn_valid),
        .insn         (insn),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow),
        .ex_ctrl      (ex_ctrl),
        .wb           (wb),
        .ovf          (ovf)
    );

    // the registered writeback lands here one edge after it appears on wb
    regfile regfile_i (
        .clock     (clock),
        .rst       (rst),
        .wr        (wb),
        .rd_idx_a  (ex_ctrl.rs),
        .rd_idx_b  (ex_ctrl.rt),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b)
    );

    operand_bypass operand_bypass_i (
        .ex_ctrl (ex_ctrl),
        .rf_a    (rf_a),
        .rf_b    (rf_b),
        .wb      (wb),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    alu alu_i (
        .op_a     (op_a),
        .op_b     (op_b),
        .alu_op   (ex_ctrl.alu_op),
        .shamt    (ex_ctrl.shamt),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

endmodule

//--- rtl/exec_control.sv
// execute control: instruction decode, immediate select, overflow redirect, writeback register
`timescale 1ns/100ps
`include "exec_core_cfg.svh"

module exec_control (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    insn_valid,
    input  exec_core_pkg::insn_u    insn,
    input  logic [`DATA_WIDTH-1:0]  alu_result,
    input  logic                    alu_overflow,
    output exec_core_pkg::ex_ctrl_t ex_ctrl,
    output exec_core_pkg::wb_t      wb,
    output logic                    ovf
);

    import exec_core_pkg::*;

    localparam logic [`REG_IDX_W-1:0] STATUS_IDX = `REG_IDX_W'(`RSTATUS_REG);

    logic                   is_r;
    logic                   is_i;
    logic                   r_legal;
    logic                   legal;
    logic [`REG_IDX_W-1:0]  dest;
    logic [`DATA_WIDTH-1:0] ovf_code;
    logic                   accept;

    // ############################################################
    // decode
    // ############################################################

    assign is_r = (insn.r.opcode == OP_ALU);
    assign is_i = (insn.i.opcode == OP_ADDI);

    // register-type words are only legal with a known function code
    always_comb begin
        case (insn.r.alu_op)
            ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRA: r_legal = 1'b1;
            default: r_legal = 1'b0;
        endcase
    end

    assign legal  = (is_r && r_legal) || is_i;
    assign accept = insn_valid && legal;

    always_comb begin
        ex_ctrl    = '0;
        // rs and rd sit in the same bits in both views
        ex_ctrl.rs = insn.r.rs;
        dest       = insn.r.rd;
        if (is_i) begin
            ex_ctrl.rt        = '0;
            ex_ctrl.alu_op    = ALU_ADD; // addi is an add with the immediate on port B
            ex_ctrl.use_imm   = 1'b1;
            // size cast of a signed field sign-extends to the full width
            ex_ctrl.imm_value = `DATA_WIDTH'($signed(insn.i.imm));
            ex_ctrl.shamt     = '0;
        end else begin
            ex_ctrl.rt        = insn.r.rt;
            ex_ctrl.alu_op    = insn.r.alu_op;
            ex_ctrl.use_imm   = 1'b0;
            ex_ctrl.imm_value = '0;
            ex_ctrl.shamt     = insn.r.shamt;
        end
    end

    // ############################################################
    // overflow redirect
    // ############################################################

    // status code 1 is add, 2 is addi and 3 is sub
    always_comb begin
        if (is_i) begin
            ovf_code = `DATA_WIDTH'(2);
        end else if (insn.r.alu_op == ALU_SUB) begin
            ovf_code = `DATA_WIDTH'(3);
        end else begin
            ovf_code = `DATA_WIDTH'(1);
        end
    end

    // ############################################################
    // writeback register
    // ############################################################

    always_ff @(posedge clock) begin
        if (rst) begin
            wb.valid <= 1'b0;
            ovf      <= 1'b0;
        end else begin
            wb.valid <= accept;
            ovf      <= accept && alu_overflow; // only add and sub can raise it
        end
    end

    // target and data are loaded every cycle and only matter when valid
    always_ff @(posedge clock) begin
        if (alu_overflow) begin
            wb.rd   <= STATUS_IDX;
            wb.data <= ovf_code;
        end else begin
            wb.rd   <= dest;
            wb.data <= alu_result;
        end
    end

    // ############################################################
    // checks
    // ############################################################

    wb_follows_insn: assert property (
        @(posedge clock) disable iff (rst)
        wb.valid |-> $past(insn_valid)
    ) else $error("exec_control: writeback without an issued instruction");

    ovf_targets_status: assert property (
        @(posedge clock) disable iff (rst)
        ovf |-> (wb.valid && (wb.rd == STATUS_IDX))
    ) else $error("exec_control: overflow not redirected to status register");

endmodule

//--- rtl/operand_bypass.sv
// operand bypass: forwards the pending writeback onto a matching read and muxes in the immediate
`timescale 1ns/100ps
`include "exec_core_cfg.svh"

module operand_bypass (
    input  exec_core_pkg::ex_ctrl_t ex_ctrl,
    input  logic [`DATA_WIDTH-1:0]  rf_a,
    input  logic [`DATA_WIDTH-1:0]  rf_b,
    input  exec_core_pkg::wb_t      wb,
    output logic [`DATA_WIDTH-1:0]  op_a,
    output logic [`DATA_WIDTH-1:0]  op_b
);

    logic wb_live;
    logic hit_a;
    logic hit_b;

    // a pending write to r0 never reaches the array, so it must not forward either
    assign wb_live = wb.valid && (wb.rd != '0);

    assign hit_a = wb_live && (wb.rd == ex_ctrl.rs);
    assign hit_b = wb_live && (wb.rd == ex_ctrl.rt);

    assign op_a = hit_a ? wb.data : rf_a;

    // the immediate wins over any forwarded register value
    always_comb begin
        if (ex_ctrl.use_imm) begin
            op_b = ex_ctrl.imm_value;
        end else if (hit_b) begin
            op_b = wb.data;
        end else begin
            op_b = rf_b;
        end
    end

endmodule

//--- rtl/alu.sv
// alu: add, sub, and, or, sll, sra with signed overflow flag on add and sub
`timescale 1ns/100ps
`include "exec_core_cfg.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] op_a,
    input  logic [`DATA_WIDTH-1:0] op_b,
    input  exec_core_pkg::alu_op_e alu_op,
    input  logic [`REG_IDX_W-1:0]  shamt,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   overflow
);

    import exec_core_pkg::*;

    localparam int MSB = `DATA_WIDTH - 1;

    logic [`DATA_WIDTH-1:0] sum;
    logic [`DATA_WIDTH-1:0] diff;
    logic                   add_ovf;
    logic                   sub_ovf;

    // ############################################################
    // arithmetic
    // ############################################################

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // same-sign operands whose sum flips sign
    assign add_ovf = (op_a[MSB] == op_b[MSB]) && (sum[MSB] != op_a[MSB]);

    // for subtraction the operand signs must differ before the result can wrap
    assign sub_ovf = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);

    // ############################################################
    // function select
    // ############################################################

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                result   = sum;
                overflow = add_ovf;
            end
            ALU_SUB: begin
                result   = diff;
                overflow = sub_ovf;
            end
            ALU_AND: begin
                result = op_a & op_b;
            end
            ALU_OR: begin
                result = op_a | op_b;
            end
            ALU_SLL: begin
                result = op_a << shamt; // zeros fill from the bottom
            end
            ALU_SRA: begin
                result = $signed(op_a) >>> shamt; // sign bit is replicated
            end
            default: begin
                result   = '0; // decoder filters these out before writeback
                overflow = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/regfile.sv
// register file: 32 by 32 array, one write port, two combinational read ports, r0 reads zero
`timescale 1ns/100ps
`include "exec_core_cfg.svh"

module regfile (
    input  logic                   clock,
    input  logic                   rst,
    input  exec_core_pkg::wb_t     wr,
    input  logic [`REG_IDX_W-1:0]  rd_idx_a,
    input  logic [`REG_IDX_W-1:0]  rd_idx_b,
    output logic [`DATA_WIDTH-1:0] rd_data_a,
    output logic [`DATA_WIDTH-1:0] rd_data_b
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   wr_en;

    // ############################################################
    // write port
    // ############################################################

    // r0 is never a legal target, the write is simply dropped
    assign wr_en = wr.valid && (wr.rd != '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data; // visible to readers after this edge
        end
    end

    // ############################################################
    // read ports
    // ############################################################

    // two independent selects, no internal write-through
    // a same-cycle write is covered by the bypass stage
    always_comb begin
        if (rd_idx_a == '0) begin
            rd_data_a = '0;
        end else begin
            rd_data_a = regs[rd_idx_a];
        end
    end

    always_comb begin
        if (rd_idx_b == '0) begin
            rd_data_b = '0;
        end else begin
            rd_data_b = regs[rd_idx_b];
        end
    end

    // ############################################################
    // checks
    // ############################################################

    // entry 0 must stay clear whatever the write port is handed over time
    r0_stays_zero: assert property (
        @(posedge clock) disable iff (rst)
        regs[0] == '0
    ) else $error("regfile: r0 storage was written");

endmodule

//--- rtl/exec_core_pkg.sv
// execute core types: instruction formats and union, opcode and alu enums, wb and ex_ctrl structs
`include "exec_core_cfg.svh"

package exec_core_pkg;

    // ############################################################
    // encodings
    // ############################################################

    typedef enum logic [4:0] {
        OP_ALU  = 5'd0, // register-type, function picked by alu_op
        OP_ADDI = 5'd5
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    // ############################################################
    // instruction word
    // ############################################################

    typedef struct packed {
        opcode_e               opcode;
        logic [`REG_IDX_W-1:0] rd;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] shamt;
        alu_op_e               alu_op;
        logic [1:0]            zero; // unused low bits of the register-type word
    } r_fmt_t;

    // the immediate takes every bit left below rs
    typedef struct packed {
        opcode_e                                      opcode;
        logic [`REG_IDX_W-1:0]                        rd;
        logic [`REG_IDX_W-1:0]                        rs;
        logic signed [`DATA_WIDTH-5-2*`REG_IDX_W-1:0] imm;
    } i_fmt_t;

    // opcode and register fields sit in the same place in both views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } insn_u;

    // ############################################################
    // datapath bundles
    // ############################################################

    typedef struct packed {
        logic                   valid;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`DATA_WIDTH-1:0] data;
    } wb_t;

    typedef struct packed {
        logic [`REG_IDX_W-1:0]  rs;
        logic [`REG_IDX_W-1:0]  rt;
        alu_op_e                alu_op;
        logic                   use_imm;   // operand B comes from imm_value
        logic [`DATA_WIDTH-1:0] imm_value; // already sign-extended
        logic [`REG_IDX_W-1:0]  shamt;
    } ex_ctrl_t;

endpackage

//--- include/exec_core_cfg.svh
// sizing macros for the execute core: register count, data width, index width, status register
`ifndef EXEC_CORE_CFG_SVH
`define EXEC_CORE_CFG_SVH

// ############################################################
// register file geometry
// ############################################################

`define REG_COUNT 32 // entry 0 is the hard-wired zero

`define DATA_WIDTH 32

`define REG_IDX_W 5 // enough bits to address REG_COUNT entries

// ############################################################
// status register
// ############################################################

// add, addi and sub overflow codes are written here instead of to rd
`define RSTATUS_REG 30

`endif
